/* list.f */
common/memPkg.sv
dataRam/waitStateTimer.sv
dataRam/dataRam.sv
src/storeFormatter.sv
src/memAccessFsm.sv
src/loadExtender.sv
src/memSubsystem.sv
bench/memSubsystemTb.sv

/* bench/memSubsystemTb.sv */
`default_nettype none

module memSubsystemTb import memPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          WAIT_STATES  = 2;
    localparam int          RAM_WORDS    = 64;
    localparam int          RAM_BYTES    = RAM_WORDS * 8;
    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 2;
    localparam int          STALL_LIMIT  = WAIT_STATES + 4;
    localparam logic [31:0] SEED         = 32'hfbf8_34bc;
    localparam logic [63:0] TOP_BITS     = 64'h8080_8080_8080_8080; // Bit 7 of every lane.

    typedef struct {
        memOp_t      op;
        logic [63:0] addr;       // aluOut, the address for memory ops.
        logic [63:0] storeData;
        bit          flushAtEnd;
    } entry_t;

    logic      clk;
    logic      reset;
    logic      flush;
    execData_t dataE;
    memData_t  dataM;
    logic      loadUseStall;

    entry_t     stimTable[$];
    logic [7:0] refBytes[RAM_BYTES]; // Byte-addressed reference memory.
    bit         tableBuilt;

    memSubsystem #(
        .WAIT_STATES(WAIT_STATES),
        .RAM_WORDS  (RAM_WORDS)
    ) i_dut (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .dataE       (dataE),
        .dataM       (dataM),
        .loadUseStall(loadUseStall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic failRun(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // Inputs change 2 ns after the rising edge.
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    function automatic logic [63:0] randomWord();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $urandom;
        lo = $urandom;
        return {hi, lo};
    endfunction

    function automatic bit isLoad(input memOp_t op);
        return op inside {LB, LH, LW, LD, LBU, LHU, LWU};
    endfunction

    function automatic bit isStore(input memOp_t op);
        return op inside {SB, SH, SW, SD};
    endfunction

    function automatic bit isSignedLoad(input memOp_t op);
        return op inside {LB, LH, LW};
    endfunction

    function automatic int accessBytes(input memOp_t op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic int byteIndex(input logic [63:0] addr);
        return int'(addr % RAM_BYTES);
    endfunction

    // Loads read n bytes little endian, then extend; everything else passes aluOut.
    function automatic logic [63:0] expectedWriteData(input entry_t e);
        logic [63:0] value;
        int          n;
        int          base;
        if (!isLoad(e.op)) begin
            return e.addr;
        end
        n     = accessBytes(e.op);
        base  = byteIndex(e.addr);
        value = '0;
        for (int k = n - 1; k >= 0; k--) begin
            value = {value[55:0], refBytes[base + k]};
        end
        if (isSignedLoad(e.op) && value[8 * n - 1]) begin
            value = value | (~64'd0 << (8 * n));
        end
        return value;
    endfunction

    task automatic applyStore(input entry_t e);
        int base;
        base = byteIndex(e.addr);
        for (int k = 0; k < accessBytes(e.op); k++) begin
            refBytes[base + k] = e.storeData[8 * k +: 8];
        end
    endtask

    task automatic addEntry(input memOp_t op, input logic [63:0] addr,
                            input logic [63:0] setBits, input logic [63:0] clearBits,
                            input bit flushAtEnd);
        entry_t e;
        e.op         = op;
        e.addr       = (op == ALU) ? randomWord() : addr; // ALU result is random.
        e.storeData  = (randomWord() | setBits) & ~clearBits;
        e.flushAtEnd = flushAtEnd;
        stimTable.push_back(e);
    endtask

    task automatic buildTable();
        addEntry(SD,  64'h040, '0, '0, 1'b0); // Whole word round trip.
        addEntry(LD,  64'h040, '0, '0, 1'b1);
        addEntry(SD,  64'h080, '0, '0, 1'b0); // Partial stores merge into it.
        addEntry(SB,  64'h081, '0, '0, 1'b0);
        addEntry(SH,  64'h082, '0, '0, 1'b1);
        addEntry(SW,  64'h084, '0, '0, 1'b0);
        addEntry(LD,  64'h080, '0, '0, 1'b1);
        addEntry(SD,  64'h0c0, TOP_BITS, '0, 1'b0); // Negative lanes.
        addEntry(LB,  64'h0c5, '0, '0, 1'b0);
        addEntry(LH,  64'h0c2, '0, '0, 1'b0);
        addEntry(LW,  64'h0c4, '0, '0, 1'b0);
        addEntry(LBU, 64'h0c5, '0, '0, 1'b0);
        addEntry(LHU, 64'h0c2, '0, '0, 1'b0);
        addEntry(LWU, 64'h0c4, '0, '0, 1'b1);
        addEntry(ALU, '0, '0, '0, 1'b0);
        addEntry(SD,  64'h100, '0, TOP_BITS, 1'b0); // Positive lanes.
        addEntry(LB,  64'h107, '0, '0, 1'b0);
        addEntry(LH,  64'h106, '0, '0, 1'b0);
        addEntry(LW,  64'h100, '0, '0, 1'b1);
        addEntry(ALU, '0, '0, '0, 1'b1);
        addEntry(SW,  64'h1f4, 64'h8000_0000, '0, 1'b0);
        addEntry(LW,  64'h1f4, '0, '0, 1'b1);
        addEntry(LWU, 64'h1f4, '0, '0, 1'b1);
        addEntry(LD,  64'h040, '0, '0, 1'b0);
        addEntry(SH,  64'h046, 64'h8000, '0, 1'b1);
        addEntry(LH,  64'h046, '0, '0, 1'b0);
        addEntry(LD,  64'h040, '0, '0, 1'b1);
        tableBuilt = 1'b1;
    endtask

    task automatic driveEntry(input entry_t e, input int idx);
        dataE.ctl.op        = e.op;
        dataE.ctl.memAccess = isLoad(e.op) || isStore(e.op);
        dataE.dst           = 5'(idx);
        dataE.aluOut        = e.addr;
        dataE.storeData     = e.storeData;
    endtask

    // Wait for the stall to rise and fall, counting the cycles of both phases.
    task automatic runAccess(output int riseCycles, output int stallCycles);
        riseCycles  = 0;
        stallCycles = 0;
        while (loadUseStall !== 1'b1) begin
            assert (riseCycles < STALL_LIMIT)
                else failRun("loadUseStall never rose for a memory access");
            tick();
            riseCycles++;
        end
        while (loadUseStall === 1'b1) begin
            assert (stallCycles < STALL_LIMIT)
                else failRun("loadUseStall stayed high, the access never finished");
            tick();
            stallCycles++;
        end
    endtask

    initial begin
        longint limitNs;
        wait (tableBuilt);
        limitNs = longint'(stimTable.size() * (WAIT_STATES + 6) + RESET_CYCLES + 4) * CLK_PERIOD;
        #(limitNs);
        failRun($sformatf("Watchdog expired after %0d ns, the run did not finish", limitNs));
    end

    initial begin
        entry_t      e;
        logic [63:0] expected;
        execCtl_t    expectedCtl;
        int          riseCycles;
        int          stallCycles;
        reset      = 1'b1;
        flush      = 1'b0;
        dataE      = '0;
        tableBuilt = 1'b0;
        void'($urandom(SEED));
        buildTable();

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int i = 0; i < stimTable.size(); i++) begin
            e                     = stimTable[i];
            expected              = expectedWriteData(e);
            expectedCtl.op        = e.op;
            expectedCtl.memAccess = isLoad(e.op) || isStore(e.op);
            driveEntry(e, i);
            if (dataE.ctl.memAccess) begin
                runAccess(riseCycles, stallCycles);
                assert (stallCycles == WAIT_STATES + 1)
                    else failRun($sformatf("[FAIL] entry %0d stall length got %h expected %h",
                                           i, stallCycles, WAIT_STATES + 1));
                assert (riseCycles + stallCycles == WAIT_STATES + 2)
                    else failRun($sformatf("[FAIL] entry %0d access latency got %h expected %h",
                                           i, riseCycles + stallCycles, WAIT_STATES + 2));
            end else begin
                assert (loadUseStall === 1'b0)
                    else failRun($sformatf("[FAIL] entry %0d loadUseStall got %h expected 0",
                                           i, loadUseStall));
                tick();
                assert (loadUseStall === 1'b0)
                    else failRun($sformatf("[FAIL] entry %0d loadUseStall got %h expected 0",
                                           i, loadUseStall));
            end

            assert (dataM.writeData === expected)
                else failRun($sformatf("[FAIL] entry %0d %s dataM.writeData got %h expected %h",
                                       i, e.op.name(), dataM.writeData, expected));
            assert (dataM.memAddr === e.addr)
                else failRun($sformatf("[FAIL] entry %0d dataM.memAddr got %h expected %h",
                                       i, dataM.memAddr, e.addr));
            assert (dataM.dst === 5'(i))
                else failRun($sformatf("[FAIL] entry %0d dataM.dst got %h expected %h",
                                       i, dataM.dst, 5'(i)));
            assert (dataM.ctl === expectedCtl)
                else failRun($sformatf("[FAIL] entry %0d dataM.ctl got %h expected %h",
                                       i, dataM.ctl, expectedCtl));

            if (isStore(e.op)) begin
                applyStore(e);
            end

            // Release the stage from OVER.
            if (e.flushAtEnd) begin
                flush = 1'b1;
                tick();
                flush = 1'b0;
            end else if (dataE.ctl.memAccess) begin
                dataE.ctl.op        = NOP;
                dataE.ctl.memAccess = 1'b0;
                tick();
            end
        end

        dataE.ctl.op        = NOP;
        dataE.ctl.memAccess = 1'b0;
        repeat (2) tick();
        assert (loadUseStall === 1'b0)
            else failRun($sformatf("[FAIL] idle loadUseStall got %h expected 0", loadUseStall));

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src/memSubsystem.sv */
`default_nettype none

module memSubsystem import memPkg::*; #(
    parameter int WAIT_STATES = 2,
    parameter int RAM_WORDS   = 64
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  execData_t dataE,
    output memData_t  dataM,
    output logic      loadUseStall
);

    busReq_t     dreq;
    busResp_t    dresp;
    logic        reqValid;
    logic [63:0] memOut;

    storeFormatter i_storeFormatter (
        .dataE   (dataE),
        .reqValid(reqValid),
        .dreq    (dreq)
    );

    memAccessFsm i_accessFsm (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .ctl         (dataE.ctl),
        .byteOffset  (dataE.aluOut[2:0]),
        .dresp       (dresp),
        .reqValid    (reqValid),
        .loadUseStall(loadUseStall),
        .memOut      (memOut)
    );

    dataRam #(
        .RAM_WORDS  (RAM_WORDS),
        .WAIT_STATES(WAIT_STATES)
    ) i_dataRam (
        .clk  (clk),
        .reset(reset),
        .dreq (dreq),
        .dresp(dresp)
    );

    loadExtender i_loadExtender (
        .dataE (dataE),
        .memOut(memOut),
        .dataM (dataM)
    );

endmodule

`default_nettype wire

/* src/loadExtender.sv */
`default_nettype none

module loadExtender import memPkg::*; (
    input  execData_t   dataE,
    input  logic [63:0] memOut,
    output memData_t    dataM
);

    busWord_t loadWord;
    logic [7:0]  loadByte;
    logic [15:0] loadHalf;
    logic [31:0] loadWordLow;

    assign loadWord.word = memOut;

    assign loadByte    = loadWord.bytes[0];
    assign loadHalf    = loadWord.word[15:0];
    assign loadWordLow = loadWord.word[31:0];

    always_comb begin
        dataM.ctl     = dataE.ctl;
        dataM.dst     = dataE.dst;
        dataM.memAddr = dataE.aluOut;

        case (dataE.ctl.op)
            LB: begin
                dataM.writeData = {{56{loadByte[7]}}, loadByte};
            end
            LH: begin
                dataM.writeData = {{48{loadHalf[15]}}, loadHalf};
            end
            LW: begin
                dataM.writeData = {{32{loadWordLow[31]}}, loadWordLow};
            end
            LBU: begin
                dataM.writeData = {56'd0, loadByte};
            end
            LHU: begin
                dataM.writeData = {48'd0, loadHalf};
            end
            LWU: begin
                dataM.writeData = {32'd0, loadWordLow};
            end
            LD: begin
                dataM.writeData = loadWord.word;
            end
            default: begin
                dataM.writeData = dataE.aluOut; // ALU result and stores.
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/memAccessFsm.sv */
`default_nettype none

module memAccessFsm import memPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,
    input  execCtl_t    ctl,
    input  logic [2:0]  byteOffset,
    input  busResp_t    dresp,
    output logic        reqValid,
    output logic        loadUseStall,
    output logic [63:0] memOut
);

    typedef enum logic [1:0] {
        IDLE,
        WAITING,
        OVER
    } accessState_t;

    accessState_t state;
    accessState_t stateNext;

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (ctl.memAccess) begin
                    stateNext = WAITING;
                end
            end
            WAITING: begin
                if (dresp.dataOk) begin
                    stateNext = OVER;
                end
            end
            OVER: begin
                // Source moved on or flushed.
                if (flush || !ctl.memAccess) begin
                    stateNext = IDLE;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // Response lanes moved down to bit 0.
    always_ff @(posedge clk) begin
        if (state == WAITING && dresp.dataOk) begin
            memOut <= dresp.data.word >> {byteOffset, 3'b000};
        end
    end

    assign reqValid     = (state == WAITING);
    assign loadUseStall = (state == WAITING); // Pipeline held during the access.

    respOnlyWhileWaiting: assert property (
        @(posedge clk) disable iff (reset) dresp.dataOk |-> state == WAITING
    ) else $error("dataOk outside WAITING, state %0d", state);

endmodule

`default_nettype wire

/* src/storeFormatter.sv */
`default_nettype none

module storeFormatter import memPkg::*; (
    input  execData_t dataE,
    input  logic      reqValid,
    output busReq_t   dreq
);

    logic [2:0] byteOffset;
    logic [7:0] laneMask;
    logic [2:0] alignMask;
    logic       isStore;

    assign byteOffset = dataE.aluOut[2:0];
    assign isStore    = dataE.ctl.op inside {SB, SH, SW, SD};

    always_comb begin
        case (dataE.ctl.op)
            LD, SD:      dreq.size = SIZE8;
            LW, LWU, SW: dreq.size = SIZE4;
            LH, LHU, SH: dreq.size = SIZE2;
            default:     dreq.size = SIZE1;
        endcase
    end

    always_comb begin
        case (dreq.size)
            SIZE8:   laneMask = 8'hff;
            SIZE4:   laneMask = 8'h0f;
            SIZE2:   laneMask = 8'h03;
            default: laneMask = 8'h01;
        endcase
    end

    assign alignMask = 3'((4'd1 << dreq.size) - 4'd1);

    assign dreq.valid  = reqValid;
    assign dreq.addr   = dataE.aluOut;
    assign dreq.strobe = isStore ? laneMask << byteOffset : 8'h00; // Loads write nothing.
    assign dreq.data   = busWord_t'(dataE.storeData << {byteOffset, 3'b000});

    // The source only issues naturally aligned accesses.
    always_comb begin
        if (reqValid) begin
            alignedAccess: assert #0 ((byteOffset & alignMask) == 3'b000)
                else $error("misaligned access at %h, size %0d", dreq.addr, dreq.size);
        end
    end

endmodule

`default_nettype wire

/* dataRam/dataRam.sv */
`default_nettype none

module dataRam import memPkg::*; #(
    parameter int RAM_WORDS   = 64,
    parameter int WAIT_STATES = 2
) (
    input  logic     clk,
    input  logic     reset,
    input  busReq_t  dreq,
    output busResp_t dresp
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    busWord_t         mem [RAM_WORDS];
    busWord_t         merged;
    logic [IDX_W-1:0] wordIdx;
    logic             timerBusy;
    logic             timerDone;

    assign wordIdx = dreq.addr[3 +: IDX_W]; // Double-word index.

    waitStateTimer #(
        .WAIT_STATES(WAIT_STATES)
    ) i_timer (
        .clk  (clk),
        .reset(reset),
        .start(dreq.valid && !timerBusy),
        .busy (timerBusy),
        .done (timerDone)
    );

    // Stored word with the strobed lanes replaced.
    always_comb begin
        merged = mem[wordIdx];
        for (int i = 0; i < 8; i++) begin
            if (dreq.strobe[i]) begin
                merged.bytes[i] = dreq.data.bytes[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (timerDone) begin
            mem[wordIdx] <= merged;
        end
    end

    assign dresp.dataOk = timerDone;
    assign dresp.data   = merged; // Read data reflects the write.

    // Requester keeps valid up until it is answered.
    validHeldToResp: assert property (
        @(posedge clk) disable iff (reset) (timerBusy || dresp.dataOk) |-> dreq.valid
    ) else $error("request dropped before dataOk, addr %h", dreq.addr);

endmodule

`default_nettype wire

/* dataRam/waitStateTimer.sv */
`default_nettype none

module waitStateTimer #(
    parameter int WAIT_STATES = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic busy,
    output logic done
);

    localparam int CNT_W = (WAIT_STATES > 1) ? $clog2(WAIT_STATES) : 1;
    localparam logic [CNT_W-1:0] LOAD_VAL = CNT_W'(WAIT_STATES - 1);

    if (WAIT_STATES < 1) begin : g_badParam
        $error("waitStateTimer needs at least one wait state");
    end

    logic [CNT_W-1:0] count;

    assign done = busy && (count == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (done) begin
            busy <= 1'b0; // Back to idle.
        end else if (busy) begin
            count <= count - 1'b1;
        end else if (start) begin
            busy  <= 1'b1;
            count <= LOAD_VAL;
        end
    end

    // An answered request must not start a second count right away.
    noReloadAfterDone: assert property (
        @(posedge clk) disable iff (reset) done |=> !start
    ) else $error("timer restarted in the cycle after done");

endmodule

`default_nettype wire

/* common/memPkg.sv */
`default_nettype none

package memPkg;

    // Operation seen by the memory stage.
    typedef enum logic [3:0] {
        NOP,
        ALU,
        LB,
        LH,
        LW,
        LD,
        LBU,
        LHU,
        LWU,
        SB,
        SH,
        SW,
        SD
    } memOp_t;

    typedef enum logic [1:0] {
        SIZE1, // 1 byte.
        SIZE2,
        SIZE4,
        SIZE8
    } accessSize_t;

    // Bus word, seen whole or as byte lanes.
    typedef union packed {
        logic [63:0]      word;
        logic [7:0][7:0]  bytes; // Lane 0 is the low byte.
    } busWord_t;

    typedef struct packed {
        memOp_t op;
        logic   memAccess; // Load or store.
    } execCtl_t;

    typedef struct packed {
        execCtl_t    ctl;
        logic [4:0]  dst;
        logic [63:0] aluOut;    // Address or result.
        logic [63:0] storeData; // rs2 value.
    } execData_t;

    typedef struct packed {
        execCtl_t    ctl;
        logic [4:0]  dst;
        logic [63:0] memAddr;
        logic [63:0] writeData;
    } memData_t;

    typedef struct packed {
        logic        valid;
        logic [63:0] addr;
        accessSize_t size;
        logic [7:0]  strobe;
        busWord_t    data;
    } busReq_t;

    // dataOk is a one-cycle pulse.
    typedef struct packed {
        logic     dataOk;
        busWord_t data;
    } busResp_t;

endpackage

`default_nettype wire
